// File: fetch_subsys.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/ifetch_wb_master.sv
logic/fetch_stage.sv
logic/wb_arbiter.sv
logic/fetch_subsys.sv
tests/tb_clock_gen.sv
tests/tb_wb_memory.sv
tests/tb_fetch_subsys.sv

// File: logic/fetch_pkg.sv
/*
 * Fetch package
 * Instruction encodings, bus error tags and reset vector shared by
 * the fetch path and the memory bus
 */
`default_nettype none

package fetch_pkg;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Tag lines sampled together with err
	typedef logic [3:0] tag_t;

	//////////////////////////////
	// Instruction encodings
	//////////////////////////////

	// OR32 l.nop, immediate carries a marker for substituted slots
	localparam logic [31:0] NOP_INSN = {6'b000101, 26'h041_0000};

	//////////////////////////////
	// Bus error tags
	//////////////////////////////

	// Translation miss in the instruction TLB
	localparam tag_t TAG_TLB_MISS = 4'hd;
	// Protection fault from the instruction MMU
	localparam tag_t TAG_MMU_FAULT = 4'hc;
	// Plain bus error, no translation involved
	localparam tag_t TAG_BUS_ERR = 4'hb;

	//////////////////////////////
	// Reset vector
	//////////////////////////////

	// First fetch address once reset is released
	localparam logic [31:0] RESET_PC = 32'h0000_0100;

endpackage

`default_nettype wire

// File: logic/fetch_stage.sv
/*
 * Instruction fetch stage
 * Presents instruction and PC to decode, keeps a word that lands while
 * decode is frozen, substitutes a NOP and flags fetch exceptions
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	// Pipeline control
	input  wire logic              freeze_i,
	input  wire logic              flush_i,
	input  wire logic              kill_i,
	// Response from the fetch master
	input  wire logic              rsp_valid_i,
	input  wire logic              rsp_err_i,
	input  wire logic [31:0]       rsp_data_i,
	input  wire fetch_pkg::tag_t   rsp_tag_i,
	input  wire logic [ADDR_W-1:0] rsp_pc_i,
	// Word taken by decode
	output logic                   advance_o,
	// Toward decode
	output logic      [31:0]       insn_o,
	output logic      [ADDR_W-1:0] pc_o,
	output logic                   stall_o,
	output logic                   exc_tlb_miss_o,
	output logic                   exc_mmu_fault_o,
	output logic                   exc_bus_err_o
);

	logic              saved_q;
	logic [31:0]       insn_saved_q;
	logic [ADDR_W-1:0] pc_saved_q;
	// Bit 0 TLB miss, bit 1 MMU fault, bit 2 bus error
	logic [2:0]        exc_saved_q;
	logic [2:0]        exc_live;
	logic [2:0]        exc_sel;
	logic              save_word;
	logic              word_avail;

	// Decode frozen when a word lands, keep it for later
	assign save_word  = rsp_valid_i & freeze_i & ~saved_q;
	assign word_avail = rsp_valid_i | saved_q;

	// Tag decode only counts with err
	assign exc_live[0] = rsp_valid_i & rsp_err_i & (rsp_tag_i == fetch_pkg::TAG_TLB_MISS);
	assign exc_live[1] = rsp_valid_i & rsp_err_i & (rsp_tag_i == fetch_pkg::TAG_MMU_FAULT);
	assign exc_live[2] = rsp_valid_i & rsp_err_i & (rsp_tag_i == fetch_pkg::TAG_BUS_ERR);

	//////////////////////////////
	// Saved word
	//////////////////////////////

	// Cleared on flush, or once decode runs again and takes the word
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save_word) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			saved_q <= 1'b0;
		end
	end

	// Only looked at while saved_q is set
	always_ff @(posedge clk) begin
		if (save_word) begin
			// Erroring fetch is kept as a NOP
			insn_saved_q <= rsp_err_i ? fetch_pkg::NOP_INSN : rsp_data_i;
			pc_saved_q   <= rsp_pc_i;
			exc_saved_q  <= exc_live;
		end
	end

	//////////////////////////////
	// Decode side outputs
	//////////////////////////////

	always_comb begin
		if (kill_i | flush_i | ~word_avail) begin
			insn_o = fetch_pkg::NOP_INSN;
		end else if (saved_q) begin
			insn_o = insn_saved_q;
		end else if (rsp_err_i) begin
			insn_o = fetch_pkg::NOP_INSN;
		end else begin
			insn_o = rsp_data_i;
		end
	end

	assign pc_o    = saved_q ? pc_saved_q : rsp_pc_i;
	// High until a word shows up
	assign stall_o = ~word_avail;

	// Nothing advances while frozen or redirected
	assign advance_o = word_avail & ~freeze_i & ~flush_i;

	// Killed slot or flushed word raises no exception
	assign exc_sel         = saved_q ? exc_saved_q : exc_live;
	assign exc_tlb_miss_o  = exc_sel[0] & ~kill_i & ~flush_i;
	assign exc_mmu_fault_o = exc_sel[1] & ~kill_i & ~flush_i;
	assign exc_bus_err_o   = exc_sel[2] & ~kill_i & ~flush_i;

endmodule

`default_nettype wire

// File: logic/fetch_subsys.sv
/*
 * Instruction fetch subsystem
 * PC generator, fetch master and fetch stage on one Wishbone bus,
 * shared with an external debug port
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_subsys #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  wire logic                clk,
	input  wire logic                arst_n_i,
	// Pipeline control
	input  wire logic                freeze_i,
	input  wire logic                flush_i,
	input  wire logic [ADDR_W-1:0]   flush_pc_i,
	input  wire logic                kill_i,
	// Toward decode
	output logic      [31:0]         insn_o,
	output logic      [ADDR_W-1:0]   pc_o,
	output logic                     stall_o,
	output logic                     exc_tlb_miss_o,
	output logic                     exc_mmu_fault_o,
	output logic                     exc_bus_err_o,
	// Debug master port
	input  wire logic                dbg_cyc_i,
	input  wire logic                dbg_stb_i,
	input  wire logic                dbg_we_i,
	input  wire logic [ADDR_W-1:0]   dbg_adr_i,
	input  wire logic [DATA_W-1:0]   dbg_dat_i,
	input  wire logic [DATA_W/8-1:0] dbg_sel_i,
	output logic      [DATA_W-1:0]   dbg_dat_o,
	output logic                     dbg_ack_o,
	output logic                     dbg_err_o,
	// Memory bus
	output logic                     wb_cyc_o,
	output logic                     wb_stb_o,
	output logic                     wb_we_o,
	output logic      [ADDR_W-1:0]   wb_adr_o,
	output logic      [DATA_W-1:0]   wb_dat_o,
	output logic      [DATA_W/8-1:0] wb_sel_o,
	input  wire logic [DATA_W-1:0]   wb_dat_i,
	input  wire logic                wb_ack_i,
	input  wire logic                wb_err_i,
	input  wire fetch_pkg::tag_t     wb_tag_i
);

	// PC and handshake between the fetch blocks
	logic [ADDR_W-1:0] pc;
	logic              advance;
	logic              rsp_valid;
	logic              rsp_err;
	logic [31:0]       rsp_data;
	fetch_pkg::tag_t   rsp_tag;
	logic [ADDR_W-1:0] rsp_pc;
	// Fetch master toward the arbiter
	logic              f_cyc;
	logic              f_stb;
	logic [ADDR_W-1:0] f_adr;
	logic [31:0]       f_dat;
	logic              f_ack;
	logic              f_err;
	fetch_pkg::tag_t   f_tag;

	pc_gen #(
		.ADDR_W(ADDR_W)
	) u_pc_gen (
		.clk(clk), .arst_n_i(arst_n_i),
		.advance_i(advance), .flush_i(flush_i), .flush_pc_i(flush_pc_i),
		.pc_o(pc)
	);

	ifetch_wb_master #(
		.ADDR_W(ADDR_W)
	) u_ifetch_wb_master (
		.clk(clk), .arst_n_i(arst_n_i),
		.pc_i(pc), .advance_i(advance), .flush_i(flush_i),
		.wb_cyc_o(f_cyc), .wb_stb_o(f_stb), .wb_adr_o(f_adr),
		.wb_dat_i(f_dat), .wb_ack_i(f_ack), .wb_err_i(f_err), .wb_tag_i(f_tag),
		.rsp_valid_o(rsp_valid), .rsp_err_o(rsp_err), .rsp_data_o(rsp_data),
		.rsp_tag_o(rsp_tag), .rsp_pc_o(rsp_pc)
	);

	fetch_stage #(
		.ADDR_W(ADDR_W)
	) u_fetch_stage (
		.clk(clk), .arst_n_i(arst_n_i),
		.freeze_i(freeze_i), .flush_i(flush_i), .kill_i(kill_i),
		.rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err), .rsp_data_i(rsp_data),
		.rsp_tag_i(rsp_tag), .rsp_pc_i(rsp_pc),
		.advance_o(advance), .insn_o(insn_o), .pc_o(pc_o), .stall_o(stall_o),
		.exc_tlb_miss_o(exc_tlb_miss_o), .exc_mmu_fault_o(exc_mmu_fault_o),
		.exc_bus_err_o(exc_bus_err_o)
	);

	// Debug takes the bus ahead of fetch
	wb_arbiter #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) u_wb_arbiter (
		.clk(clk), .arst_n_i(arst_n_i),
		.m0_cyc_i(f_cyc), .m0_stb_i(f_stb), .m0_adr_i(f_adr),
		.m0_dat_o(f_dat), .m0_ack_o(f_ack), .m0_err_o(f_err), .m0_tag_o(f_tag),
		.m1_cyc_i(dbg_cyc_i), .m1_stb_i(dbg_stb_i), .m1_we_i(dbg_we_i),
		.m1_adr_i(dbg_adr_i), .m1_dat_i(dbg_dat_i), .m1_sel_i(dbg_sel_i),
		.m1_dat_o(dbg_dat_o), .m1_ack_o(dbg_ack_o), .m1_err_o(dbg_err_o),
		.s_cyc_o(wb_cyc_o), .s_stb_o(wb_stb_o), .s_we_o(wb_we_o),
		.s_adr_o(wb_adr_o), .s_dat_o(wb_dat_o), .s_sel_o(wb_sel_o),
		.s_dat_i(wb_dat_i), .s_ack_i(wb_ack_i), .s_err_i(wb_err_i),
		.s_tag_i(wb_tag_i)
	);

endmodule

`default_nettype wire

// File: logic/ifetch_wb_master.sv
/*
 * Instruction fetch bus master
 * Reads one word per Wishbone classic cycle at the current PC and
 * hands the response, tagged with its address, to the fetch stage
 */
`timescale 1ns/1ns
`default_nettype none

module ifetch_wb_master #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	// From PC generator and fetch stage
	input  wire logic [ADDR_W-1:0] pc_i,
	input  wire logic              advance_i,
	input  wire logic              flush_i,
	// Wishbone master side
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic      [ADDR_W-1:0] wb_adr_o,
	input  wire logic [31:0]       wb_dat_i,
	input  wire logic              wb_ack_i,
	input  wire logic              wb_err_i,
	input  wire fetch_pkg::tag_t   wb_tag_i,
	// Response toward the fetch stage
	output logic                   rsp_valid_o,
	output logic                   rsp_err_o,
	output logic      [31:0]       rsp_data_o,
	output fetch_pkg::tag_t        rsp_tag_o,
	output logic      [ADDR_W-1:0] rsp_pc_o
);

	// Idle only right after reset, done waits for decode to take the word
	typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} state_t;

	state_t            state_q;
	// First cycle of a read, address comes straight from the PC
	logic              first_q;
	// Open read was overtaken by a flush
	logic              discard_q;
	logic [ADDR_W-1:0] adr_q;
	logic              xfer_end;
	logic              restart;

	assign xfer_end = (state_q == S_BUSY) & (wb_ack_i | wb_err_i);
	// Any of these ends the word in flight and opens the next read at once
	assign restart = discard_q | flush_i | advance_i;

	//////////////////////////////
	// Bus request
	//////////////////////////////

	assign wb_cyc_o = (state_q == S_BUSY);
	assign wb_stb_o = (state_q == S_BUSY);
	// PC is already updated in the first cycle, then the latched copy holds it
	assign wb_adr_o = first_q ? pc_i : adr_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= S_IDLE;
			first_q   <= 1'b0;
			discard_q <= 1'b0;
			adr_q     <= ADDR_W'(fetch_pkg::RESET_PC);
		end else begin
			adr_q   <= wb_adr_o;
			first_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					state_q <= S_BUSY;
					first_q <= 1'b1;
				end
				S_BUSY: begin
					if (xfer_end) begin
						discard_q <= 1'b0;
						if (restart) begin
							first_q <= 1'b1;
						end else begin
							// Decode frozen, word saved in the stage
							state_q <= S_DONE;
						end
					end else if (flush_i) begin
						// Cannot abort, finish the cycle and drop its data
						discard_q <= 1'b1;
					end
				end
				default: begin
					if (flush_i | advance_i) begin
						state_q <= S_BUSY;
						first_q <= 1'b1;
					end
				end
			endcase
		end
	end

	//////////////////////////////
	// Response
	//////////////////////////////

	// Stale reads and responses in a flush cycle never reach decode
	assign rsp_valid_o = xfer_end & ~discard_q & ~flush_i;
	assign rsp_err_o   = wb_err_i;
	assign rsp_data_o  = wb_dat_i;
	assign rsp_tag_o   = wb_tag_i;
	assign rsp_pc_o    = wb_adr_o;

endmodule

`default_nettype wire

// File: logic/pc_gen.sv
/*
 * Program counter generator
 * Steps the fetch address by one word per delivered instruction and
 * takes a redirect target when the pipeline is flushed
 */
`timescale 1ns/1ns
`default_nettype none

module pc_gen #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	// Word handed to decode this cycle
	input  wire logic              advance_i,
	// Pipeline redirect
	input  wire logic              flush_i,
	input  wire logic [ADDR_W-1:0] flush_pc_i,
	// Current fetch address
	output logic      [ADDR_W-1:0] pc_o
);

	// Word-aligned redirect target
	logic [ADDR_W-1:0] flush_target;
	// Sequential successor
	logic [ADDR_W-1:0] pc_step;
	logic [ADDR_W-1:0] pc_q;

	// Instructions are word aligned, drop the byte offset
	assign flush_target = {flush_pc_i[ADDR_W-1:2], 2'b00};

	assign pc_step = pc_q + ADDR_W'(4);

	//////////////////////////////
	// PC register
	//////////////////////////////

	// Flush has priority over a normal step
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= ADDR_W'(fetch_pkg::RESET_PC);
		end else if (flush_i) begin
			pc_q <= flush_target;
		end else if (advance_i) begin
			pc_q <= pc_step;
		end
	end

	// Held between steps, so the fetch master sees a stable address
	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: logic/wb_arbiter.sv
/*
 * Wishbone arbiter
 * Shares one classic bus between fetch and debug, debug first,
 * with the grant held for the whole of a transfer
 */
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  wire logic                clk,
	input  wire logic                arst_n_i,
	// Master 0, instruction fetch, read only
	input  wire logic                m0_cyc_i,
	input  wire logic                m0_stb_i,
	input  wire logic [ADDR_W-1:0]   m0_adr_i,
	output logic      [31:0]         m0_dat_o,
	output logic                     m0_ack_o,
	output logic                     m0_err_o,
	output fetch_pkg::tag_t          m0_tag_o,
	// Master 1, debug port
	input  wire logic                m1_cyc_i,
	input  wire logic                m1_stb_i,
	input  wire logic                m1_we_i,
	input  wire logic [ADDR_W-1:0]   m1_adr_i,
	input  wire logic [DATA_W-1:0]   m1_dat_i,
	input  wire logic [DATA_W/8-1:0] m1_sel_i,
	output logic      [DATA_W-1:0]   m1_dat_o,
	output logic                     m1_ack_o,
	output logic                     m1_err_o,
	// Shared slave bus
	output logic                     s_cyc_o,
	output logic                     s_stb_o,
	output logic                     s_we_o,
	output logic      [ADDR_W-1:0]   s_adr_o,
	output logic      [DATA_W-1:0]   s_dat_o,
	output logic      [DATA_W/8-1:0] s_sel_o,
	input  wire logic [DATA_W-1:0]   s_dat_i,
	input  wire logic                s_ack_i,
	input  wire logic                s_err_i,
	input  wire fetch_pkg::tag_t     s_tag_i
);

	// Owner 1 is debug
	logic owner;
	logic owner_q;
	logic locked_q;

	// Free bus goes to debug whenever it asks
	assign owner = locked_q ? owner_q : m1_cyc_i;

	//////////////////////////////
	// Grant lock
	//////////////////////////////

	// Held through wait states, dropped when the owner ends or leaves
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			owner_q  <= 1'b0;
			locked_q <= 1'b0;
		end else begin
			owner_q  <= owner;
			locked_q <= s_cyc_o & ~(s_ack_i | s_err_i);
		end
	end

	//////////////////////////////
	// Request mux
	//////////////////////////////

	assign s_cyc_o = owner ? m1_cyc_i : m0_cyc_i;
	assign s_stb_o = owner ? m1_stb_i : m0_stb_i;
	// Fetch never writes
	assign s_we_o  = owner & m1_we_i;
	assign s_adr_o = owner ? m1_adr_i : m0_adr_i;
	assign s_dat_o = owner ? m1_dat_i : '0;
	// Fetch always reads the full word
	assign s_sel_o = owner ? m1_sel_i : '1;

	// Responses go to the owner only
	assign m0_ack_o = s_ack_i & ~owner & m0_cyc_i;
	assign m0_err_o = s_err_i & ~owner & m0_cyc_i;
	assign m0_dat_o = s_dat_i[31:0];
	assign m0_tag_o = s_tag_i;
	assign m1_ack_o = s_ack_i & owner & m1_cyc_i;
	assign m1_err_o = s_err_i & owner & m1_cyc_i;
	assign m1_dat_o = s_dat_i;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f fetch_subsys.f \
	--top-module tb_fetch_subsys -o sim_fetch_subsys &&
./obj_dir/sim_fetch_subsys | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 40 ns clock, reset held low for the first four cycles
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic arst_n_i
);

	initial begin
		clk      = 1'b0;
		arst_n_i = 1'b0;
		repeat (4) @(posedge clk);
		// Release just after the edge, away from sampling
		#2 arst_n_i = 1'b1;
	end

	always #20 clk = ~clk;

endmodule

`default_nettype wire

// File: tests/tb_fetch_subsys.sv
/*
 * Fetch subsystem testbench
 * Random freeze, kill, flush and debug traffic against a PC reference model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_subsys;

	localparam int STIM_CYCLES = 3000;
	localparam int LIMIT       = 2 * (STIM_CYCLES + 8);
	localparam int DBG_PAIRS   = 40;

	logic        clk, arst_n_i;
	logic        freeze_i, flush_i, kill_i;
	logic [31:0] flush_pc_i;
	logic [31:0] insn_o, pc_o;
	logic        stall_o, exc_tlb_miss_o, exc_mmu_fault_o, exc_bus_err_o;
	logic        dbg_cyc_i, dbg_stb_i, dbg_we_i;
	logic [31:0] dbg_adr_i, dbg_dat_i, dbg_dat_o;
	logic [3:0]  dbg_sel_i;
	logic        dbg_ack_o, dbg_err_o;
	logic        wb_cyc_o, wb_stb_o, wb_we_o;
	logic [31:0] wb_adr_o, wb_dat_o, wb_dat_i;
	logic [3:0]  wb_sel_o, wb_tag_i;
	logic        wb_ack_i, wb_err_i;

	// Reference model and previous-cycle samples
	logic [31:0] exp_pc, rnd, rdata, wdat, old_word, exp_rd;
	// Debug thread draws from its own stream
	logic [31:0] dbg_rnd;
	logic [31:0] prev_insn, prev_pc, prev_adr;
	logic [2:0]  exc, exp_exc, prev_exc;
	logic [3:0]  wsel;
	logic        prev_freeze, prev_stall, prev_flush, prev_kill, prev_busy, prev_we;
	int          deliveries, cycle_cnt;

	tb_clock_gen u_clk (.clk(clk), .arst_n_i(arst_n_i));

	tb_wb_memory u_mem (
		.clk(clk), .arst_n_i(arst_n_i),
		.cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o), .adr_i(wb_adr_o),
		.dat_i(wb_dat_o), .sel_i(wb_sel_o), .dat_o(wb_dat_i), .ack_o(wb_ack_i),
		.err_o(wb_err_i), .tag_o(wb_tag_i)
	);

	fetch_subsys #(.ADDR_W(32), .DATA_W(32)) u_dut (
		.clk(clk), .arst_n_i(arst_n_i),
		.freeze_i(freeze_i), .flush_i(flush_i), .flush_pc_i(flush_pc_i), .kill_i(kill_i),
		.insn_o(insn_o), .pc_o(pc_o), .stall_o(stall_o),
		.exc_tlb_miss_o(exc_tlb_miss_o), .exc_mmu_fault_o(exc_mmu_fault_o),
		.exc_bus_err_o(exc_bus_err_o),
		.dbg_cyc_i(dbg_cyc_i), .dbg_stb_i(dbg_stb_i), .dbg_we_i(dbg_we_i),
		.dbg_adr_i(dbg_adr_i), .dbg_dat_i(dbg_dat_i), .dbg_sel_i(dbg_sel_i),
		.dbg_dat_o(dbg_dat_o), .dbg_ack_o(dbg_ack_o), .dbg_err_o(dbg_err_o),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i), .wb_err_i(wb_err_i), .wb_tag_i(wb_tag_i)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Same hash the memory is preloaded with
	function automatic logic [31:0] expected_word(input logic [31:0] adr);
		return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]};
	endfunction

	// One flag per error-region word index, bus error for the upper two
	function automatic logic [2:0] exc_for_pc(input logic [31:0] pc);
		case (pc[3:2])
			2'd0:    return 3'b001;
			2'd1:    return 3'b010;
			default: return 3'b100;
		endcase
	endfunction

	// Mostly plain code, now and then a few words into the error region
	function automatic logic [31:0] pick_flush_target(input logic [31:0] r);
		if (r[1:0] == 2'd0) begin
			return 32'h0000_1000 | {27'd0, r[4:2], r[6:5]};
		end
		return (32'h0000_0100 + {21'd0, r[16:8], 2'b00}) | {30'd0, r[6:5]};
	endfunction

	task automatic abort_run(input string msg);
		$display("TESTS FAILED");
		$display("%s", msg);
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
	                               input logic [31:0] act_v);
		abort_run($sformatf("Error at %0t: %s expected %h actual %h",
		                    $time, name, exp_v, act_v));
	endtask

	// Single debug cycle, held until ack or err
	task automatic dbg_transfer(input logic we, input logic [31:0] adr,
	                            input logic [31:0] dat, input logic [3:0] sel,
	                            output logic [31:0] rd);
		@(posedge clk);
		#2;
		dbg_cyc_i = 1'b1;
		dbg_stb_i = 1'b1;
		dbg_we_i  = we;
		dbg_adr_i = adr;
		dbg_dat_i = dat;
		dbg_sel_i = sel;
		do begin
			@(negedge clk);
		end while (!(dbg_ack_o || dbg_err_o));
		rd = dbg_dat_o;
		assert (!dbg_err_o) else abort_run("Debug transfer ended with a bus error");
		@(posedge clk);
		#2;
		dbg_cyc_i = 1'b0;
		dbg_stb_i = 1'b0;
		dbg_we_i  = 1'b0;
	endtask

	//////////////////////////////
	// Checks at the falling edge
	//////////////////////////////

	assign exc = {exc_bus_err_o, exc_mmu_fault_o, exc_tlb_miss_o};

	always @(negedge clk) begin
		if (!arst_n_i) begin
			assert (!wb_cyc_o && !wb_stb_o)
				else report_mismatch("wb_cyc_o", 0, 32'(wb_cyc_o));
			assert (stall_o) else report_mismatch("stall_o", 1, 32'(stall_o));
			assert (exc == 3'b000) else report_mismatch("exc", 0, 32'(exc));
			assert (!dbg_ack_o) else report_mismatch("dbg_ack_o", 0, 32'(dbg_ack_o));
			assert (insn_o == fetch_pkg::NOP_INSN)
				else report_mismatch("insn_o", fetch_pkg::NOP_INSN, insn_o);
			exp_pc     = fetch_pkg::RESET_PC;
			prev_busy  = 1'b0;
			prev_stall = 1'b1;
		end else begin
			if (flush_i) begin
				assert (insn_o == fetch_pkg::NOP_INSN)
					else report_mismatch("insn_o", fetch_pkg::NOP_INSN, insn_o);
				assert (exc == 3'b000) else report_mismatch("exc", 0, 32'(exc));
			end else if (!stall_o) begin
				assert (pc_o == exp_pc) else report_mismatch("pc_o", exp_pc, pc_o);
				if (kill_i || pc_o >= 32'h0000_1000) begin
					assert (insn_o == fetch_pkg::NOP_INSN)
						else report_mismatch("insn_o", fetch_pkg::NOP_INSN, insn_o);
				end else begin
					assert (insn_o == expected_word(pc_o))
						else report_mismatch("insn_o", expected_word(pc_o), insn_o);
				end
				exp_exc = (kill_i || pc_o < 32'h0000_1000) ? 3'b000 : exc_for_pc(pc_o);
				assert (exc == exp_exc)
					else report_mismatch("exc", 32'(exp_exc), 32'(exc));
			end else begin
				assert (exc == 3'b000) else report_mismatch("exc", 0, 32'(exc));
			end
			// Frozen word holds still
			if (prev_freeze && freeze_i && !prev_stall && !prev_flush && !flush_i &&
			    kill_i == prev_kill) begin
				assert (insn_o == prev_insn) else report_mismatch("insn_o", prev_insn, insn_o);
				assert (pc_o == prev_pc) else report_mismatch("pc_o", prev_pc, pc_o);
				assert (exc == prev_exc)
					else report_mismatch("exc", 32'(prev_exc), 32'(exc));
			end
			// Grant stays with one owner until its transfer ends
			if (prev_busy) begin
				assert (wb_cyc_o && wb_adr_o == prev_adr && wb_we_o == prev_we)
					else report_mismatch("wb_adr_o", prev_adr, wb_adr_o);
			end
			assert (!wb_cyc_o || (dbg_cyc_i && wb_adr_o == dbg_adr_i) ||
			        (u_dut.f_cyc && wb_adr_o == u_dut.f_adr))
				else abort_run("Bus address belongs to neither master");
			assert (!(dbg_ack_o && u_dut.f_ack))
				else abort_run("Response reached both masters in one cycle");
			// Reference PC
			if (flush_i) begin
				exp_pc = {flush_pc_i[31:2], 2'b00};
			end else if (!stall_o && !freeze_i) begin
				exp_pc     = exp_pc + 32'd4;
				deliveries = deliveries + 1;
			end
			prev_busy = wb_cyc_o && !wb_ack_i && !wb_err_i;
			prev_adr  = wb_adr_o;
			prev_we   = wb_we_o;
			prev_stall = stall_o;
		end
		prev_insn   = insn_o;
		prev_pc     = pc_o;
		prev_exc    = exc;
		prev_freeze = freeze_i;
		prev_flush  = flush_i;
		prev_kill   = kill_i;
	end

	// Hang guard
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			abort_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		rnd        = 32'd68456;
		dbg_rnd    = 32'd68456;
		deliveries = 0;
		cycle_cnt  = 0;
		freeze_i   = 1'b0;
		flush_i    = 1'b0;
		kill_i     = 1'b0;
		flush_pc_i = 32'd0;
		dbg_cyc_i  = 1'b0;
		dbg_stb_i  = 1'b0;
		dbg_we_i   = 1'b0;
		dbg_adr_i  = 32'd0;
		dbg_dat_i  = 32'd0;
		dbg_sel_i  = 4'd0;
		wait (arst_n_i);
		fork
			begin
				for (int c = 0; c < STIM_CYCLES; c++) begin
					@(posedge clk);
					#2;
					rnd        = xorshift32(rnd);
					freeze_i   = (rnd[1:0] == 2'd0);
					kill_i     = (rnd[4:2] == 3'd0);
					// Keep fetch clear of the debug area and past the error words
					flush_i    = (rnd[9:5] == 5'd0) || exp_pc >= 32'h0000_1020 ||
					             (exp_pc >= 32'h0000_0A00 && exp_pc < 32'h0000_1000);
					flush_pc_i = pick_flush_target(xorshift32(rnd));
				end
			end
			begin
				for (int k = 0; k < DBG_PAIRS; k++) begin
					dbg_rnd = xorshift32(dbg_rnd);
					repeat (dbg_rnd[3:0]) @(posedge clk);
					wdat     = xorshift32(dbg_rnd);
					wsel     = dbg_rnd[7:4];
					old_word = expected_word(32'h0000_0C00 + 32'(k * 4));
					exp_rd   = (old_word & ~{{8{wsel[3]}}, {8{wsel[2]}}, {8{wsel[1]}},
					            {8{wsel[0]}}}) | (wdat & {{8{wsel[3]}}, {8{wsel[2]}},
					            {8{wsel[1]}}, {8{wsel[0]}}});
					dbg_transfer(1'b1, 32'h0000_0C00 + 32'(k * 4), wdat, wsel, rdata);
					dbg_transfer(1'b0, 32'h0000_0C00 + 32'(k * 4), 32'd0, 4'hf, rdata);
					assert (rdata == exp_rd) else report_mismatch("dbg_dat_o", exp_rd, rdata);
				end
			end
		join
		if (deliveries < STIM_CYCLES / 10) begin
			abort_run("Fetch delivered too few instructions");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_wb_memory.sv
/*
 * Wishbone slave memory model
 * 4 KiB of preloaded words, random wait states, error tags above 0x1000
 */
`timescale 1ns/1ns
`default_nettype none

module tb_wb_memory (
	input  wire logic        clk,
	input  wire logic        arst_n_i,
	input  wire logic        cyc_i,
	input  wire logic        stb_i,
	input  wire logic        we_i,
	input  wire logic [31:0] adr_i,
	input  wire logic [31:0] dat_i,
	input  wire logic [3:0]  sel_i,
	output logic      [31:0] dat_o,
	output logic             ack_o,
	output logic             err_o,
	output logic      [3:0]  tag_o
);

	logic [31:0] mem [0:1023];
	logic [31:0] rnd;
	logic [1:0]  wait_q;
	logic [31:0] mask;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Contents are a hash of the full byte address
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]};
	endfunction

	initial begin
		rnd = 32'd68456;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = fill_word({20'd0, i[9:0], 2'b00});
		end
	end

	assign mask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

	// Registered response, never two in a row
	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o  <= 1'b0;
			err_o  <= 1'b0;
			dat_o  <= 32'd0;
			tag_o  <= 4'd0;
			wait_q <= 2'd0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			if (cyc_i && stb_i && !ack_o && !err_o) begin
				if (wait_q != 2'd0) begin
					wait_q <= wait_q - 2'd1;
				end else begin
					rnd    = xorshift32(rnd);
					wait_q <= rnd[1:0];
					if (adr_i >= 32'h0000_1000) begin
						// Error region, tag picked by word index
						err_o <= 1'b1;
						dat_o <= 32'd0;
						case (adr_i[3:2])
							2'd0:    tag_o <= fetch_pkg::TAG_TLB_MISS;
							2'd1:    tag_o <= fetch_pkg::TAG_MMU_FAULT;
							default: tag_o <= fetch_pkg::TAG_BUS_ERR;
						endcase
					end else begin
						ack_o <= 1'b1;
						tag_o <= 4'd0;
						dat_o <= mem[adr_i[11:2]];
						if (we_i) begin
							mem[adr_i[11:2]] <= (mem[adr_i[11:2]] & ~mask) | (dat_i & mask);
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
